// File: common/orbPkg.sv
`default_nettype none

package orbPkg;

	// ******************************
	// widths
	// ******************************
	localparam int dataW = 8;     // input byte.
	localparam int wordW = 12;    // formatted frame word.
	localparam int slotBits = 4;
	localparam int packBits = 6;
	localparam int addrW = 11;

	// ******************************
	// packet layout
	// ******************************
	localparam int dataSlots = 16;   // stored bytes per channel.
	localparam int syncSlots = 2;    // frame-sync bytes, counted only.

	// one frame address seen two ways.
	// flat index for the memory side, fields for the packer side.
	typedef union packed {
		logic [addrW-1:0] flat;
		struct packed {
			logic [packBits-1:0] packet;
			logic [slotBits-1:0] slot;
			logic chan;      // 0 even, 1 odd.
		} fld;
	} orbAddrU;

endpackage

`default_nettype wire

// File: common/orbRdIf.sv
`timescale 1ns/1ps
`default_nettype none

// read port of the frame memory, data one clock after en.
interface orbRdIf;

	logic en;
	orbPkg::orbAddrU addr;
	logic page;
	logic [orbPkg::wordW-1:0] data;

	modport rdr (
		output en,
		output addr,
		output page,
		input data
	);

	modport ram (
		input en,
		input addr,
		input page,
		output data
	);

endinterface

`default_nettype wire

// File: common/orbWrIf.sv
`timescale 1ns/1ps
`default_nettype none

// single write port into the frame memory.
interface orbWrIf;

	logic we;                           // one word per high cycle.
	orbPkg::orbAddrU addr;
	logic [orbPkg::wordW-1:0] word;
	logic page;

	modport ctrl (
		output we,
		output addr,
		output word,
		output page
	);

	modport ram (
		input we,
		input addr,
		input word,
		input page
	);

endinterface

`default_nettype wire

// File: dv/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
	parameter int halfPeriod = 10,
	parameter int rstCycles = 8
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#halfPeriod clk = ~clk;
		end
	end

	// reset drops just after a rising edge.
	initial begin
		rst = 1'b0;
		repeat (rstCycles) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/orbTb.sv
`timescale 1ns/1ps
`default_nettype none

module orbTb;

	localparam int dataW = orbPkg::dataW;
	localparam int wordW = orbPkg::wordW;
	localparam int addrW = orbPkg::addrW;

	logic clk;
	logic rst;
	logic [dataW-1:0] data0;
	logic [dataW-1:0] data1;
	logic strob0;
	logic strob1;
	logic pageSw;
	logic rdReq;
	logic [addrW-1:0] rdAddr;
	logic rdAck;
	logic [wordW-1:0] rdData;
	logic pageSwap;

	logic [wordW-1:0] sb [2][1 << addrW];    // expected memory per page.
	logic [wordW-1:0] syncQ [$];              // formatted sync bytes of channel 0.
	int slotCnt [2];
	int pktCnt [2];
	logic wrPage;
	int seed;

	clkGen clock (.clk(clk), .rst(rst));

	orbTop #(.weDelay(28)) uut (
		.clk(clk), .rst(rst), .data0(data0), .data1(data1), .strob0(strob0),
		.strob1(strob1), .pageSw(pageSw), .rdReq(rdReq), .rdAddr(rdAddr),
		.rdAck(rdAck), .rdData(rdData), .pageSwap(pageSwap)
	);

	// ******************************
	// reference model
	// ******************************
	function automatic logic [wordW-1:0] expWord(input logic [dataW-1:0] b);
		return {1'b0, b, 3'b000};
	endfunction

	function automatic int expAddr(input int packet, input int slot, input int chan);
		return packet * 32 + slot * 2 + chan;
	endfunction

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkVal(input string name, input logic [wordW-1:0] expV,
			input logic [wordW-1:0] actV);
		if (actV !== expV) begin
			abortRun($sformatf("FAILED %s: expected %03h, actual %03h", name, expV, actV));
		end
	endtask

	task automatic readWord(input int a, output logic [wordW-1:0] d);
		int n;
		rdAddr = addrW'(a);
		rdReq = 1'b1;
		n = 0;
		while (rdAck !== 1'b1) begin
			tick();
			n++;
			if (n > 20) begin
				abortRun("read handshake timed out");
			end
		end
		d = rdData;
		rdReq = 1'b0;
		n = 0;
		while (rdAck !== 1'b0) begin
			tick();
			n++;
			if (n > 20) begin
				abortRun("read handshake timed out");
			end
		end
	endtask

	// slots 16 and 17 are sync bytes, never stored.
	task automatic record(input logic ch, input logic [dataW-1:0] b);
		if (slotCnt[ch] < 16) begin
			sb[wrPage][addrW'(expAddr(pktCnt[ch], slotCnt[ch], int'(ch)))] = expWord(b);
		end else if (ch == 1'b0) begin
			syncQ.push_back(expWord(b));
		end
		slotCnt[ch]++;
		if (slotCnt[ch] == 18) begin
			slotCnt[ch] = 0;
			pktCnt[ch]++;
		end
	endtask

	task automatic sendByte(input logic [1:0] chMask, input logic [dataW-1:0] b0,
			input logic [dataW-1:0] b1);
		data0 = b0;
		data1 = b1;
		strob0 = chMask[0];
		strob1 = chMask[1];
		if (chMask[0]) record(1'b0, b0);
		if (chMask[1]) record(1'b1, b1);
		repeat (40) tick();    // write lands well before the strobe drops.
		strob0 = 1'b0;
		strob1 = 1'b0;
		repeat (6) tick();
	endtask

	task automatic flipPage(input string name);
		int n;
		pageSw = ~pageSw;
		n = 0;
		while (pageSwap !== 1'b1) begin
			tick();
			n++;
			if (n > 10) begin
				abortRun("pageSwap did not pulse after a page switch");
			end
		end
		tick();
		checkVal($sformatf("%s pageSwap width", name), '0, wordW'(pageSwap));
		wrPage = ~wrPage;
		slotCnt = '{0, 0};
		pktCnt = '{0, 0};
	endtask

	task automatic checkRange(input string name, input int first, input int last, input int step);
		logic [wordW-1:0] d;
		for (int a = first; a <= last; a += step) begin
			readWord(a, d);
			checkVal($sformatf("%s @%0d", name, a), sb[!wrPage][addrW'(a)], d);
		end
	endtask

	// ******************************
	// tests
	// ******************************
	initial begin
		logic [wordW-1:0] d;
		int n;
		int r;
		seed = 32'h401a728d;
		data0 = '0;
		data1 = '0;
		strob0 = 1'b0;
		strob1 = 1'b0;
		pageSw = 1'b0;
		rdReq = 1'b0;
		rdAddr = '0;
		wrPage = 1'b0;
		slotCnt = '{0, 0};
		pktCnt = '{0, 0};
		n = 0;
		while (rst !== 1'b1) begin
			tick();
			n++;
			if (n > 20) begin
				abortRun("reset was never released");
			end
		end

		repeat (10) begin
			tick();
			checkVal("reset rdAck", '0, wordW'(rdAck));
			checkVal("reset pageSwap", '0, wordW'(pageSwap));
		end

		for (int i = 1; i <= 18; i++) begin
			sendByte(2'b01, dataW'(8'h30 + i), '0);
		end
		flipPage("single chan");
		for (int i = 0; i < 16; i++) begin
			readWord(expAddr(0, i, 0), d);
			checkVal("single chan word", expWord(dataW'(8'h31 + i)), d);
		end

		// equal strobes, channel 1 waits a cycle for the port.
		for (int i = 0; i < 6; i++) begin
			sendByte(2'b11, dataW'(8'h50 + i), dataW'(8'h90 + i));
		end
		flipPage("dual chan");
		for (int i = 0; i < 6; i++) begin
			readWord(expAddr(0, i, 0), d);
			checkVal("dual chan even", expWord(dataW'(8'h50 + i)), d);
			readWord(expAddr(0, i, 1), d);
			checkVal("dual chan odd", expWord(dataW'(8'h90 + i)), d);
		end

		syncQ.delete();
		for (int i = 1; i <= 36; i++) begin
			if (i % 18 == 17 || i % 18 == 0) begin
				sendByte(2'b01, dataW'(8'hc0 + i), '0);
			end else begin
				sendByte(2'b01, dataW'(8'h60 + i), '0);
			end
		end
		flipPage("two packets");
		readWord(expAddr(1, 0, 0), d);
		checkVal("pkt1 slot0", expWord(dataW'(8'h60 + 19)), d);
		for (int a = 0; a < 64; a += 2) begin
			readWord(a, d);
			checkVal($sformatf("two packets @%0d", a), sb[!wrPage][addrW'(a)], d);
			foreach (syncQ[k]) begin
				checkVal("sync byte stored", '0, wordW'(d == syncQ[k]));
			end
		end

		for (int i = 0; i < 5; i++) begin
			sendByte(2'b01, dataW'(8'h20 + i), '0);
		end
		flipPage("partial");
		for (int i = 0; i < 3; i++) begin
			sendByte(2'b01, dataW'(8'ha0 + i), '0);
		end
		checkRange("old page", 0, 8, 2);
		flipPage("partial back");
		readWord(0, d);
		checkVal("counter restart", expWord(8'ha0), d);
		checkRange("new page", 0, 10, 2);

		for (int i = 0; i < 54; i++) begin
			r = $random(seed);
			sendByte(2'b11, dataW'(r), dataW'(r >> 8));
		end
		flipPage("random");
		checkRange("random", 0, 95, 1);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
common/orbPkg.sv
common/orbWrIf.sv
common/orbRdIf.sv
orbPacker/chanCapture.sv
orbPacker/packerCtrl.sv
verilog/frameRam.sv
verilog/frameReader.sv
verilog/orbTop.sv
dv/clkGen.sv
dv/orbTb.sv

// File: orbPacker/chanCapture.sv
`timescale 1ns/1ps
`default_nettype none

module chanCapture (
	input wire logic clk,
	input wire logic rst,
	input wire logic strob,
	input wire logic [orbPkg::dataW-1:0] data,
	input wire logic pageSw,
	output logic take,
	output logic [orbPkg::wordW-1:0] word,
	output logic strobLvl,
	output logic pageLvl
);

	logic [1:0] strobSync;
	logic [1:0] swSync;
	logic strobPrev;    // edge register.
	logic rise;

	// ******************************
	// synchronizers
	// ******************************
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			strobSync <= 2'b00;
			swSync <= 2'b00;
			strobPrev <= 1'b0;
			take <= 1'b0;
		end else begin
			strobSync <= {strobSync[0], strob};
			swSync <= {swSync[0], pageSw};
			strobPrev <= strobSync[1];
			take <= rise;
		end
	end

	assign rise = strobSync[1] & ~strobPrev;
	assign strobLvl = strobSync[1];
	assign pageLvl = swSync[1];

	// byte is stable while the strobe is high.
	// frame word is a zero bit, the byte, then three zeros.
	always_ff @(posedge clk) begin
		if (rise) begin
			word <= {1'b0, data, 3'b000};
		end
	end

endmodule

`default_nettype wire

// File: orbPacker/packerCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module packerCtrl #(
	parameter int weDelay = 28
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic take0,
	input wire logic take1,
	input wire logic [orbPkg::wordW-1:0] word0,
	input wire logic [orbPkg::wordW-1:0] word1,
	input wire logic strobLvl0,
	input wire logic strobLvl1,
	input wire logic pageLvl,
	output logic pageSwap,
	orbWrIf.ctrl wr,
	output logic rdPage
);

	localparam int lastSlot = orbPkg::dataSlots + orbPkg::syncSlots - 1;
	localparam int slotCntW = $clog2(lastSlot + 1);
	localparam int dlyW = $clog2(weDelay + 1);

	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] DELAY = 2'd1;
	localparam logic [1:0] WAIT = 2'd2;

	logic [1:0] takeV;
	logic [1:0] lvlV;
	logic [orbPkg::wordW-1:0] wordIn [2];
	logic [orbPkg::wordW-1:0] wordQ [2];
	orbPkg::orbAddrU addrQ [2];
	logic [1:0] req;
	logic [1:0] gnt;
	logic prevLvl;
	logic swap;
	logic wrPage;

	assign takeV = {take1, take0};
	assign lvlV = {strobLvl1, strobLvl0};
	assign wordIn[0] = word0;
	assign wordIn[1] = word1;

	// ******************************
	// page control
	// ******************************
	assign swap = pageLvl != prevLvl;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			prevLvl <= 1'b0;
			pageSwap <= 1'b0;
			wrPage <= 1'b0;
		end else begin
			prevLvl <= pageLvl;
			pageSwap <= swap;     // one cycle per change.
			if (swap) begin
				wrPage <= ~wrPage;
			end
		end
	end

	assign rdPage = ~wrPage;   // reader sees the idle page.

	// ******************************
	// channel sequencers
	// ******************************
	for (genvar ch = 0; ch < 2; ch++) begin : gChan
		logic [1:0] state;
		logic [slotCntW-1:0] slotCnt;
		logic [orbPkg::packBits-1:0] pktCnt;
		logic [dlyW-1:0] dlyCnt;
		logic [orbPkg::wordW-1:0] wordReg;
		orbPkg::orbAddrU addrReg;

		always_ff @(posedge clk or negedge rst) begin
			if (!rst) begin
				state <= IDLE;
				slotCnt <= '0;
				pktCnt <= '0;
				dlyCnt <= '0;
			end else if (swap) begin
				state <= IDLE;
				slotCnt <= '0;
				pktCnt <= '0;
				dlyCnt <= '0;
			end else begin
				case (state)
					IDLE: begin
						if (takeV[ch]) begin
							if (slotCnt < slotCntW'(orbPkg::dataSlots)) begin
								dlyCnt <= dlyW'(1);
								state <= DELAY;
							end else begin
								state <= WAIT;    // sync byte, not stored.
							end
							if (slotCnt == slotCntW'(lastSlot)) begin
								slotCnt <= '0;
								pktCnt <= pktCnt + 1'b1;
							end else begin
								slotCnt <= slotCnt + 1'b1;
							end
						end
					end
					DELAY: begin
						if (gnt[ch]) begin
							state <= WAIT;
						end else if (dlyCnt != dlyW'(weDelay)) begin
							dlyCnt <= dlyCnt + 1'b1;
						end
					end
					WAIT: begin
						if (!lvlV[ch]) begin
							state <= IDLE;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end

		// word and address are latched with the slot they belong to.
		always_ff @(posedge clk) begin
			if (state == IDLE && takeV[ch]) begin
				wordReg <= wordIn[ch];
				addrReg.fld.packet <= pktCnt;
				addrReg.fld.slot <= slotCnt[orbPkg::slotBits-1:0];
				addrReg.fld.chan <= 1'(ch);
			end
		end

		assign req[ch] = (state == DELAY) && (dlyCnt == dlyW'(weDelay));
		assign wordQ[ch] = wordReg;
		assign addrQ[ch] = addrReg;
	end

	// ******************************
	// write arbitration
	// ******************************
	assign gnt[0] = req[0];              // channel 0 wins a tie.
	assign gnt[1] = req[1] & ~req[0];

	assign wr.we = |req;
	assign wr.addr = gnt[0] ? addrQ[0] : addrQ[1];
	assign wr.word = gnt[0] ? wordQ[0] : wordQ[1];
	assign wr.page = wrPage;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the frame packer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module orbTb -o orbSim

out=$(./obj_dir/orbSim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

// File: verilog/frameRam.sv
`timescale 1ns/1ps
`default_nettype none

module frameRam #(
	parameter int pages = 2,
	parameter int depth = 2048
) (
	input wire logic clk,
	orbWrIf.ram wr,
	orbRdIf.ram rd
);

	// ******************************
	// storage
	// ******************************
	logic [orbPkg::wordW-1:0] mem [pages][depth];

	// write side.
	always_ff @(posedge clk) begin
		if (wr.we) begin
			mem[wr.page][wr.addr.flat] <= wr.word;
		end
	end

	// registered read, valid the clock after en.
	always_ff @(posedge clk) begin
		if (rd.en) begin
			rd.data <= mem[rd.page][rd.addr.flat];
		end
	end

endmodule

`default_nettype wire

// File: verilog/frameReader.sv
`timescale 1ns/1ps
`default_nettype none

module frameReader (
	input wire logic clk,
	input wire logic rst,
	input wire logic rdReq,
	input wire logic [orbPkg::addrW-1:0] rdAddr,
	input wire logic rdPage,
	output logic rdAck,
	output logic [orbPkg::wordW-1:0] rdData,
	orbRdIf.rdr rd
);

	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] FETCH = 2'd1;
	localparam logic [1:0] HOLD = 2'd2;
	localparam logic [1:0] RELEASE = 2'd3;

	logic [1:0] state;

	// ******************************
	// four-phase handshake
	// ******************************
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
			rd.en <= 1'b0;
			rdAck <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (rdReq) begin
						rd.en <= 1'b1;     // single read strobe.
						state <= FETCH;
					end
				end
				FETCH: begin
					rd.en <= 1'b0;
					state <= HOLD;
				end
				HOLD: begin
					if (!rdAck) begin
						rdAck <= 1'b1;     // memory data has landed.
					end else if (!rdReq) begin
						rdAck <= 1'b0;
						state <= RELEASE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// address and page are sampled with the request.
	always_ff @(posedge clk) begin
		if (state == IDLE && rdReq) begin
			rd.addr.flat <= rdAddr;
			rd.page <= rdPage;
		end
		if (state == HOLD && !rdAck) begin
			rdData <= rd.data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/orbTop.sv
`timescale 1ns/1ps
`default_nettype none

module orbTop #(
	parameter int weDelay = 28
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [orbPkg::dataW-1:0] data0,
	input wire logic [orbPkg::dataW-1:0] data1,
	input wire logic strob0,
	input wire logic strob1,
	input wire logic pageSw,
	input wire logic rdReq,
	input wire logic [orbPkg::addrW-1:0] rdAddr,
	output logic rdAck,
	output logic [orbPkg::wordW-1:0] rdData,
	output logic pageSwap
);

	logic take0;
	logic take1;
	logic [orbPkg::wordW-1:0] word0;
	logic [orbPkg::wordW-1:0] word1;
	logic strobLvl0;
	logic strobLvl1;
	logic pageLvl;
	logic rdPage;

	orbWrIf wrBus ();
	orbRdIf rdBus ();

	// ******************************
	// capture, one per channel
	// ******************************
	chanCapture cap0 (
		.clk(clk), .rst(rst), .strob(strob0), .data(data0), .pageSw(pageSw),
		.take(take0), .word(word0), .strobLvl(strobLvl0), .pageLvl(pageLvl)
	);

	// page switch comes in through channel 0 only.
	chanCapture cap1 (
		.clk(clk), .rst(rst), .strob(strob1), .data(data1), .pageSw(1'b0),
		.take(take1), .word(word1), .strobLvl(strobLvl1), .pageLvl()
	);

	packerCtrl #(.weDelay(weDelay)) ctrl (
		.clk(clk), .rst(rst), .take0(take0), .take1(take1),
		.word0(word0), .word1(word1), .strobLvl0(strobLvl0), .strobLvl1(strobLvl1),
		.pageLvl(pageLvl), .pageSwap(pageSwap), .wr(wrBus.ctrl), .rdPage(rdPage)
	);

	frameRam #(.pages(2), .depth(1 << orbPkg::addrW)) ram (
		.clk(clk), .wr(wrBus.ram), .rd(rdBus.ram)
	);

	frameReader rdr (
		.clk(clk), .rst(rst), .rdReq(rdReq), .rdAddr(rdAddr), .rdPage(rdPage),
		.rdAck(rdAck), .rdData(rdData), .rd(rdBus.rdr)
	);

endmodule

`default_nettype wire
